// ==== soc_pkg.sv ====
package soc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;  // one per byte lane

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_DECERR = 2'd3
    } bus_resp_e;

    typedef struct packed {
        bus_op_e op;
        addr_t   addr;
        data_t   wdata;
        strb_t   wstrb;
    } bus_req_t;

    typedef struct packed {
        data_t     rdata;
        bus_resp_e resp;
    } bus_rsp_t;

    // slave windows, S1 and S3 left empty
    localparam addr_t RAM_BASE = 32'h0000_0000;
    localparam addr_t RAM_LAST = 32'h0FFF_FFFF;
    localparam addr_t LED_BASE = 32'h2000_0000;
    localparam addr_t LED_LAST = 32'h2FFF_FFFF;

    localparam int RAM_WORDS  = 256;
    localparam int RAM_IDX_W  = $clog2(RAM_WORDS);
    localparam int BYTE_OFS_W = $clog2($bits(strb_t));

    localparam int BTN_WIDTH = 4;
    localparam int LED_WIDTH = 4;
    localparam addr_t BTN_READ_ADDR = RAM_BASE;

endpackage

// ==== bus_arbiter.sv ====
`timescale 1ns/10ps

module bus_arbiter (
    input  logic              sys_clk,
    input  logic              arst_n,
    input  soc_pkg::bus_req_t host_req,
    input  logic              host_req_valid,
    output logic              host_req_ready,
    output soc_pkg::bus_rsp_t host_rsp,
    output logic              host_rsp_valid,
    input  logic              host_rsp_ready,
    input  soc_pkg::bus_req_t btn_req,
    input  logic              btn_req_valid,
    output logic              btn_req_ready,
    output soc_pkg::bus_rsp_t btn_rsp,
    output logic              btn_rsp_valid,
    input  logic              btn_rsp_ready,
    output soc_pkg::bus_req_t bus_req,
    output logic              bus_req_valid,
    input  logic              bus_req_ready,
    input  soc_pkg::bus_rsp_t bus_rsp,
    input  logic              bus_rsp_valid,
    output logic              bus_rsp_ready
);
    logic gnt_host;
    logic gnt_btn;
    logic last_btn;  // btn master won the last grant
    logic req_sent;  // request already passed under this grant
    logic bus_idle;
    logic pick_btn;

    assign bus_idle = !gnt_host && !gnt_btn;
    assign pick_btn = btn_req_valid && (!host_req_valid || !last_btn);

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            gnt_host <= 1'b0;
            gnt_btn  <= 1'b0;
            last_btn <= 1'b0;
            req_sent <= 1'b0;
        end else if (bus_idle) begin
            if (host_req_valid || btn_req_valid) begin
                gnt_btn  <= pick_btn;
                gnt_host <= !pick_btn;
                last_btn <= pick_btn;
            end
        end else if (bus_rsp_valid && bus_rsp_ready) begin
            gnt_host <= 1'b0;  // release after the response
            gnt_btn  <= 1'b0;
            req_sent <= 1'b0;
        end else if (bus_req_valid && bus_req_ready) begin
            req_sent <= 1'b1;
        end
    end

    assign bus_req        = gnt_btn ? btn_req : host_req;
    assign bus_req_valid  = !req_sent && ((gnt_host && host_req_valid) ||
                                          (gnt_btn && btn_req_valid));
    assign host_req_ready = gnt_host && !req_sent && bus_req_ready;
    assign btn_req_ready  = gnt_btn && !req_sent && bus_req_ready;

    assign host_rsp       = bus_rsp;
    assign btn_rsp        = bus_rsp;
    assign host_rsp_valid = gnt_host && bus_rsp_valid;
    assign btn_rsp_valid  = gnt_btn && bus_rsp_valid;
    assign bus_rsp_ready  = (gnt_host && host_rsp_ready) || (gnt_btn && btn_rsp_ready);

    a_one_grant: assert property (@(posedge sys_clk) disable iff (!arst_n)
        !(gnt_host && gnt_btn));

    a_host_hold: assert property (@(posedge sys_clk) disable iff (!arst_n)
        gnt_host && host_req_valid && !host_req_ready |=> host_req_valid);

    a_btn_hold: assert property (@(posedge sys_clk) disable iff (!arst_n)
        gnt_btn && btn_req_valid && !btn_req_ready |=> btn_req_valid);

endmodule

// ==== bus_decoder.sv ====
`timescale 1ns/10ps

module bus_decoder (
    input  logic              sys_clk,
    input  logic              arst_n,
    input  soc_pkg::bus_req_t req,
    input  logic              req_valid,
    output logic              req_ready,
    output soc_pkg::bus_rsp_t rsp,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output soc_pkg::bus_req_t ram_req,
    output logic              ram_req_valid,
    input  logic              ram_req_ready,
    input  soc_pkg::bus_rsp_t ram_rsp,
    input  logic              ram_rsp_valid,
    output logic              ram_rsp_ready,
    output soc_pkg::bus_req_t led_req,
    output logic              led_req_valid,
    input  logic              led_req_ready,
    input  soc_pkg::bus_rsp_t led_rsp,
    input  logic              led_rsp_valid,
    output logic              led_rsp_ready
);
    typedef enum logic [1:0] {DEC_IDLE, DEC_RAM, DEC_LED, DEC_ERR} dec_state_e;

    dec_state_e state;  // who owns the open transaction
    logic       hit_ram;
    logic       hit_led;

    // windows are aligned powers of two
    function automatic logic in_window(soc_pkg::addr_t addr, soc_pkg::addr_t base,
                                       soc_pkg::addr_t last);
        return (addr & ~(last - base)) == base;
    endfunction

    assign hit_ram = in_window(req.addr, soc_pkg::RAM_BASE, soc_pkg::RAM_LAST);
    assign hit_led = in_window(req.addr, soc_pkg::LED_BASE, soc_pkg::LED_LAST);

    assign ram_req       = req;
    assign led_req       = req;
    assign ram_req_valid = (state == DEC_IDLE) && req_valid && hit_ram;
    assign led_req_valid = (state == DEC_IDLE) && req_valid && hit_led;

    always_comb begin
        if (state != DEC_IDLE) begin
            req_ready = 1'b0;
        end else if (hit_ram) begin
            req_ready = ram_req_ready;
        end else if (hit_led) begin
            req_ready = led_req_ready;
        end else begin
            req_ready = 1'b1;  // unmapped, answered here
        end
    end

    always_comb begin
        rsp.rdata     = '0;
        rsp.resp      = soc_pkg::RESP_DECERR;
        rsp_valid     = 1'b0;
        ram_rsp_ready = 1'b0;
        led_rsp_ready = 1'b0;
        case (state)
            DEC_RAM: begin
                rsp           = ram_rsp;
                rsp_valid     = ram_rsp_valid;
                ram_rsp_ready = rsp_ready;
            end
            DEC_LED: begin
                rsp           = led_rsp;
                rsp_valid     = led_rsp_valid;
                led_rsp_ready = rsp_ready;
            end
            DEC_ERR: rsp_valid = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= DEC_IDLE;
        end else if (state == DEC_IDLE) begin
            if (req_valid && req_ready) begin
                if (hit_ram) begin
                    state <= DEC_RAM;
                end else if (hit_led) begin
                    state <= DEC_LED;
                end else begin
                    state <= DEC_ERR;
                end
            end
        end else if (rsp_valid && rsp_ready) begin
            state <= DEC_IDLE;
        end
    end

    a_one_slave: assert property (@(posedge sys_clk) disable iff (!arst_n)
        !(ram_req_valid && led_req_valid));

endmodule

// ==== ram_slave.sv ====
`timescale 1ns/10ps

module ram_slave (
    input  logic              sys_clk,
    input  logic              arst_n,
    input  soc_pkg::bus_req_t req,
    input  logic              req_valid,
    output logic              req_ready,
    output soc_pkg::bus_rsp_t rsp,
    output logic              rsp_valid,
    input  logic              rsp_ready
);
    soc_pkg::data_t                mem [soc_pkg::RAM_WORDS];
    logic [soc_pkg::RAM_IDX_W-1:0] idx;
    logic                          xfer;

    // aliases across the whole window
    assign idx       = req.addr[soc_pkg::BYTE_OFS_W +: soc_pkg::RAM_IDX_W];
    assign req_ready = !rsp_valid;
    assign xfer      = req_valid && req_ready;

    always_ff @(posedge sys_clk) begin
        if (xfer && req.op == soc_pkg::OP_WRITE) begin
            for (int i = 0; i < $bits(soc_pkg::strb_t); i++) begin
                if (req.wstrb[i]) begin
                    mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (xfer) begin
            rsp.resp  <= soc_pkg::RESP_OKAY;
            rsp.rdata <= (req.op == soc_pkg::OP_READ) ? mem[idx] : '0;  // old word on read
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (xfer) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    a_rsp_hold: assert property (@(posedge sys_clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

// ==== led_slave.sv ====
`timescale 1ns/10ps

module led_slave (
    input  logic                          sys_clk,
    input  logic                          arst_n,
    input  soc_pkg::bus_req_t             req,
    input  logic                          req_valid,
    output logic                          req_ready,
    output soc_pkg::bus_rsp_t             rsp,
    output logic                          rsp_valid,
    input  logic                          rsp_ready,
    output logic [soc_pkg::LED_WIDTH-1:0] led
);
    soc_pkg::data_t led_q;  // same word at every address
    logic           xfer;

    assign req_ready = !rsp_valid;
    assign xfer      = req_valid && req_ready;
    assign led       = led_q[soc_pkg::LED_WIDTH-1:0];

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            led_q <= '0;
        end else if (xfer && req.op == soc_pkg::OP_WRITE) begin
            for (int i = 0; i < $bits(soc_pkg::strb_t); i++) begin
                if (req.wstrb[i]) begin
                    led_q[8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (xfer) begin
            rsp.resp  <= soc_pkg::RESP_OKAY;
            rsp.rdata <= (req.op == soc_pkg::OP_READ) ? led_q : '0;
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (xfer) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    a_rsp_hold: assert property (@(posedge sys_clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

// ==== btn_master.sv ====
`timescale 1ns/10ps

module btn_master (
    input  logic                          sys_clk,
    input  logic                          arst_n,
    input  logic [soc_pkg::BTN_WIDTH-1:0] btn,
    output soc_pkg::bus_req_t             req,
    output logic                          req_valid,
    input  logic                          req_ready,
    input  soc_pkg::bus_rsp_t             rsp,
    input  logic                          rsp_valid,
    output logic                          rsp_ready,
    output logic [soc_pkg::LED_WIDTH-1:0] recv_led
);
    typedef enum logic [2:0] {IDLE, WR_REQ, WR_RSP, RD_REQ, RD_RSP} btn_state_e;

    btn_state_e                    state;
    logic [soc_pkg::BTN_WIDTH-1:0] btn_meta;
    logic [soc_pkg::BTN_WIDTH-1:0] btn_sync;
    logic [soc_pkg::BTN_WIDTH-1:0] btn_prev;
    logic [soc_pkg::BTN_WIDTH-1:0] btn_val;  // pattern sent with the write
    logic                          press;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            btn_meta <= '0;
            btn_sync <= '0;
            btn_prev <= '0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
        end
    end

    assign press = |(btn_sync & ~btn_prev);  // any bit rising

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:   if (press) state <= WR_REQ;
                WR_REQ: if (req_valid && req_ready) state <= WR_RSP;
                WR_RSP: if (rsp_valid && rsp_ready) state <= RD_REQ;
                RD_REQ: if (req_valid && req_ready) state <= RD_RSP;
                RD_RSP: if (rsp_valid && rsp_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == IDLE && press) begin
            btn_val <= btn_sync;
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            recv_led <= '0;
        end else if (state == RD_RSP && rsp_valid && rsp.resp == soc_pkg::RESP_OKAY) begin
            recv_led <= rsp.rdata[soc_pkg::LED_WIDTH-1:0];
        end
    end

    always_comb begin
        req = '0;
        case (state)
            WR_REQ: begin
                req.op    = soc_pkg::OP_WRITE;
                req.addr  = soc_pkg::LED_BASE;
                req.wdata = soc_pkg::data_t'(btn_val);
                req.wstrb = '1;
            end
            RD_REQ: begin
                req.op   = soc_pkg::OP_READ;
                req.addr = soc_pkg::BTN_READ_ADDR;
            end
            default: ;
        endcase
    end

    assign req_valid = (state == WR_REQ) || (state == RD_REQ);
    assign rsp_ready = (state == WR_RSP) || (state == RD_RSP);

endmodule

// ==== soc_top.sv ====
`timescale 1ns/10ps

module soc_top (
    input  logic                            sys_clk,
    input  logic                            arst_n,
    input  logic [soc_pkg::BTN_WIDTH-1:0]   btn,
    output logic [2*soc_pkg::LED_WIDTH-1:0] led,
    input  soc_pkg::bus_req_t               host_req,
    input  logic                            host_req_valid,
    output logic                            host_req_ready,
    output soc_pkg::bus_rsp_t               host_rsp,
    output logic                            host_rsp_valid,
    input  logic                            host_rsp_ready
);
    soc_pkg::bus_req_t btn_req, bus_req, ram_req, led_req;
    soc_pkg::bus_rsp_t btn_rsp, bus_rsp, ram_rsp, led_rsp;
    logic btn_req_valid, btn_req_ready, btn_rsp_valid, btn_rsp_ready;
    logic bus_req_valid, bus_req_ready, bus_rsp_valid, bus_rsp_ready;
    logic ram_req_valid, ram_req_ready, ram_rsp_valid, ram_rsp_ready;
    logic led_req_valid, led_req_ready, led_rsp_valid, led_rsp_ready;
    logic [soc_pkg::LED_WIDTH-1:0] led_reg;
    logic [soc_pkg::LED_WIDTH-1:0] recv_led;

    assign led = {recv_led, led_reg};  // read-back on the upper nibble

    btn_master m1_btn (.sys_clk, .arst_n, .btn, .req(btn_req), .req_valid(btn_req_valid),
        .req_ready(btn_req_ready), .rsp(btn_rsp), .rsp_valid(btn_rsp_valid),
        .rsp_ready(btn_rsp_ready), .recv_led);

    bus_arbiter arb (.sys_clk, .arst_n, .host_req, .host_req_valid, .host_req_ready,
        .host_rsp, .host_rsp_valid, .host_rsp_ready, .btn_req, .btn_req_valid,
        .btn_req_ready, .btn_rsp, .btn_rsp_valid, .btn_rsp_ready, .bus_req, .bus_req_valid,
        .bus_req_ready, .bus_rsp, .bus_rsp_valid, .bus_rsp_ready);

    bus_decoder dec (.sys_clk, .arst_n, .req(bus_req), .req_valid(bus_req_valid),
        .req_ready(bus_req_ready), .rsp(bus_rsp), .rsp_valid(bus_rsp_valid),
        .rsp_ready(bus_rsp_ready), .ram_req, .ram_req_valid, .ram_req_ready, .ram_rsp,
        .ram_rsp_valid, .ram_rsp_ready, .led_req, .led_req_valid, .led_req_ready, .led_rsp,
        .led_rsp_valid, .led_rsp_ready);

    ram_slave s0_ram (.sys_clk, .arst_n, .req(ram_req), .req_valid(ram_req_valid),
        .req_ready(ram_req_ready), .rsp(ram_rsp), .rsp_valid(ram_rsp_valid),
        .rsp_ready(ram_rsp_ready));

    led_slave s2_led (.sys_clk, .arst_n, .req(led_req), .req_valid(led_req_valid),
        .req_ready(led_req_ready), .rsp(led_rsp), .rsp_valid(led_rsp_valid),
        .rsp_ready(led_rsp_ready), .led(led_reg));

endmodule

// ==== tb_soc_top.sv ====
`timescale 1ns/10ps

module tb_soc_top;
    typedef struct packed {
        soc_pkg::bus_op_e   op;
        soc_pkg::addr_t     addr;
        soc_pkg::data_t     wdata;
        soc_pkg::strb_t     wstrb;
        soc_pkg::data_t     exp_rdata;
        soc_pkg::bus_resp_e exp_resp;
        logic               press_after;  // raise btn once this entry is done
        logic               wait_btn;     // button sequence must finish first
    } host_entry_t;

    localparam soc_pkg::bus_op_e WR = soc_pkg::OP_WRITE;
    localparam soc_pkg::bus_op_e RD = soc_pkg::OP_READ;
    localparam logic [soc_pkg::BTN_WIDTH-1:0] BTN_PATTERN = 4'b0110;
    localparam soc_pkg::data_t BTN_WORD = 32'h0000_0009;

    logic                            sys_clk;
    logic                            arst_n;
    logic [soc_pkg::BTN_WIDTH-1:0]   btn;
    logic [2*soc_pkg::LED_WIDTH-1:0] led;
    soc_pkg::bus_req_t               host_req;
    logic                            host_req_valid;
    logic                            host_req_ready;
    soc_pkg::bus_rsp_t               host_rsp;
    logic                            host_rsp_valid;
    logic                            host_rsp_ready;

    host_entry_t    table_q[$];
    host_entry_t    cur;
    soc_pkg::data_t model_mem [soc_pkg::RAM_WORDS];
    soc_pkg::data_t model_led;
    int err_data, err_resp, err_led, err_misc;
    int cycles, limit, presses;
    logic btn_busy;

    soc_top dut0 (.sys_clk, .arst_n, .btn, .led, .host_req, .host_req_valid, .host_req_ready,
        .host_rsp, .host_rsp_valid, .host_rsp_ready);

    initial sys_clk = 1'b0;
    always #5 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic add_entry(soc_pkg::bus_op_e op, soc_pkg::addr_t addr, soc_pkg::data_t wdata,
                             soc_pkg::strb_t wstrb, logic press_after, logic wait_btn);
        host_entry_t e;
        e = '0;
        e.op          = op;
        e.addr        = addr;
        e.wdata       = wdata;
        e.wstrb       = wstrb;
        e.press_after = press_after;
        e.wait_btn    = wait_btn;
        table_q.push_back(e);
    endtask

    function automatic soc_pkg::data_t merge_bytes(soc_pkg::data_t old, soc_pkg::data_t wdata,
                                                   soc_pkg::strb_t strb);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) old[8*i +: 8] = wdata[8*i +: 8];
        end
        return old;
    endfunction

    // reference model of the memory and the LED register
    task automatic model_apply(inout host_entry_t e);
        int idx;
        idx = (e.addr >> 2) % soc_pkg::RAM_WORDS;  // aliases every RAM_WORDS words
        e.exp_rdata = '0;
        e.exp_resp  = soc_pkg::RESP_OKAY;
        if (e.addr >= soc_pkg::RAM_BASE && e.addr <= soc_pkg::RAM_LAST) begin
            if (e.op == WR) model_mem[idx] = merge_bytes(model_mem[idx], e.wdata, e.wstrb);
            else e.exp_rdata = model_mem[idx];
        end else if (e.addr >= soc_pkg::LED_BASE && e.addr <= soc_pkg::LED_LAST) begin
            if (e.op == WR) model_led = merge_bytes(model_led, e.wdata, e.wstrb);
            else e.exp_rdata = model_led;
        end else begin
            e.exp_resp = soc_pkg::RESP_DECERR;
        end
    endtask

    task automatic check_data(string name, soc_pkg::data_t act, soc_pkg::data_t exp);
        if (act !== exp) begin
            err_data++;
            $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_resp(string name, soc_pkg::bus_resp_e act, soc_pkg::bus_resp_e exp);
        if (act !== exp) begin
            err_resp++;
            $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_led(string name, logic [soc_pkg::LED_WIDTH-1:0] act,
                             logic [soc_pkg::LED_WIDTH-1:0] exp);
        if (act !== exp) begin
            err_led++;
            $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic run_entry(host_entry_t e);
        soc_pkg::bus_rsp_t held;
        int delay;
        host_req       = '{op: e.op, addr: e.addr, wdata: e.wdata, wstrb: e.wstrb};
        host_req_valid = 1'b1;
        do @(negedge sys_clk); while (!host_req_ready);
        @(posedge sys_clk);
        #1 host_req_valid = 1'b0;
        do @(negedge sys_clk); while (!host_rsp_valid);
        held  = host_rsp;
        delay = $urandom_range(3, 0);
        repeat (delay) begin  // response must hold under back-pressure
            @(negedge sys_clk);
            if (!host_rsp_valid) begin
                err_misc++;
                $display("host_rsp_valid dropped at %0t while host_rsp_ready was low", $time);
            end
            check_data("host_rsp.rdata (held)", host_rsp.rdata, held.rdata);
            check_resp("host_rsp.resp (held)", host_rsp.resp, held.resp);
        end
        @(posedge sys_clk);
        #1 host_rsp_ready = 1'b1;
        @(posedge sys_clk);
        #1 host_rsp_ready = 1'b0;
        check_data("host_rsp.rdata", held.rdata, e.exp_rdata);
        check_resp("host_rsp.resp", held.resp, e.exp_resp);
    endtask

    task automatic wait_for_button();
        int n;
        n = 0;
        while (led[7:4] == 4'h0 && n < 400) begin  // read-back nibble marks completion
            @(posedge sys_clk);
            #1 n++;
        end
        if (led[7:4] == 4'h0) begin
            err_misc++;
            $display("button sequence did not complete within 400 cycles");
        end else begin
            model_led = soc_pkg::data_t'(BTN_PATTERN);
            check_led("led[3:0]", led[3:0], BTN_PATTERN);
            check_led("led[7:4]", led[7:4], BTN_WORD[3:0]);
        end
        btn      = '0;
        btn_busy = 1'b0;
    endtask

    initial begin
        void'($urandom(32'ha2ef));
        arst_n         = 1'b0;
        btn            = '0;
        host_req       = '0;
        host_req_valid = 1'b0;
        host_rsp_ready = 1'b0;
        btn_busy       = 1'b0;
        model_led      = '0;

        add_entry(WR, 32'h0000_0010, 32'h1122_3344, 4'hf, 0, 0);
        add_entry(RD, 32'h0000_0010, '0, '0, 0, 0);
        add_entry(WR, 32'h0000_0010, 32'hAABB_CCDD, 4'h5, 0, 0);  // partial
        add_entry(RD, 32'h0000_0010, '0, '0, 0, 0);
        add_entry(WR, 32'h0000_0404, 32'hDEAD_BEEF, 4'hf, 0, 0);
        add_entry(RD, 32'h0000_0004, '0, '0, 0, 0);               // alias of 0x404
        add_entry(WR, 32'h0FFF_FFF8, 32'h0BAD_F00D, 4'hf, 0, 0);
        add_entry(RD, 32'h0000_03F8, '0, '0, 0, 0);
        add_entry(WR, 32'h2000_0000, 32'h0000_00A5, 4'hf, 0, 0);
        add_entry(RD, 32'h2345_6788, '0, '0, 0, 0);
        add_entry(WR, 32'h2000_0004, 32'h1234_5678, 4'h2, 0, 0);
        add_entry(RD, 32'h2FFF_FFFC, '0, '0, 0, 0);
        add_entry(RD, 32'h1000_0000, '0, '0, 0, 0);               // S1 has no slave
        add_entry(WR, 32'h1000_0010, 32'hFFFF_FFFF, 4'hf, 0, 0);
        add_entry(WR, 32'h3000_0000, 32'hFFFF_FFFF, 4'hf, 0, 0);
        add_entry(RD, 32'h3FFF_FFFC, '0, '0, 0, 0);
        add_entry(RD, 32'h4000_0000, '0, '0, 0, 0);
        add_entry(WR, 32'hF000_0010, 32'h0F0F_0F0F, 4'hf, 0, 0);
        add_entry(RD, 32'h0000_0010, '0, '0, 0, 0);
        add_entry(RD, 32'h2000_0000, '0, '0, 0, 0);
        add_entry(WR, soc_pkg::BTN_READ_ADDR, BTN_WORD, 4'hf, 1, 0);
        add_entry(WR, 32'h0000_0020, 32'h5555_AAAA, 4'hf, 0, 0);  // shares the bus with btn
        add_entry(RD, 32'h0000_0020, '0, '0, 0, 0);
        add_entry(WR, 32'h2000_0100, 32'h0000_00C3, 4'h1, 0, 1);
        add_entry(RD, 32'h2000_0008, '0, '0, 0, 0);
        add_entry(RD, soc_pkg::BTN_READ_ADDR, '0, '0, 0, 0);

        presses = 0;
        foreach (table_q[i]) if (table_q[i].press_after) presses++;
        limit = 60 * table_q.size() + 400 * presses;

        repeat (10) @(posedge sys_clk);
        #1 arst_n = 1'b1;
        @(negedge sys_clk);
        check_led("led[7:4]", led[7:4], 4'h0);
        check_led("led[3:0]", led[3:0], 4'h0);
        if (host_rsp_valid !== 1'b0 || host_req_ready !== 1'b0) begin
            err_misc++;
            $display("host handshake outputs not low after reset");
        end
        @(posedge sys_clk);
        #1;

        for (int i = 0; i < table_q.size(); i++) begin
            cur = table_q[i];
            if (cur.wait_btn && btn_busy) wait_for_button();
            model_apply(cur);
            run_entry(cur);
            if (!btn_busy) check_led("led[3:0]", led[3:0], model_led[3:0]);
            if (cur.press_after) begin
                btn      = BTN_PATTERN;
                btn_busy = 1'b1;
            end
        end

        $display("errors: data %0d resp %0d led %0d other %0d",
                 err_data, err_resp, err_led, err_misc);
        if (err_data + err_resp + err_led + err_misc == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
soc_pkg.sv
bus_arbiter.sv
bus_decoder.sv
ram_slave.sv
led_slave.sv
btn_master.sv
soc_top.sv
tb_soc_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_soc_top -f src.f; then
    echo "compile failed"
    exit 1
fi

if ! out=$(./obj_dir/Vtb_soc_top); then
    echo "$out"
    echo "simulation exited with an error"
    exit 1
fi
echo "$out"

if grep -qx '>>> PASS' <<< "$out"; then
    exit 0
fi
exit 1
